//--- hw/idct_pkg.sv
package idct_pkg;

	// block geometry
	localparam int BLOCK_DIM  = 8;
	localparam int BLOCK_SIZE = BLOCK_DIM * BLOCK_DIM;
	localparam int IDX_W      = 6;
	localparam int TERM_W     = $clog2(BLOCK_DIM);
	localparam int CNT_W      = IDX_W + TERM_W;
	localparam int DRAIN_LEN  = 2;

	// datapath widths
	localparam int COEF_W  = 16;
	localparam int COS_W   = 13;
	localparam int ACC_W   = 32;
	localparam int PIXEL_W = 8;

	// fixed point scaling
	localparam int COS_DC    = 1448;
	localparam int ROW_SHIFT = 8;
	localparam int COL_SHIFT = 16;
	localparam int PIXEL_MAX = 255;

	// apb register map
	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;
	localparam int WIN_LSB    = IDX_W + 2;
	localparam logic [APB_ADDR_W-1:0] COEF_BASE   = 12'h000;
	localparam logic [APB_ADDR_W-1:0] CTRL_ADDR   = 12'h100;
	localparam logic [APB_ADDR_W-1:0] STATUS_ADDR = 12'h104;
	localparam logic [APB_ADDR_W-1:0] PIXEL_BASE  = 12'h200;

	typedef enum logic [2:0] {
		IDLE, ROW_PASS, ROW_DRAIN, COL_PASS, COL_DRAIN, DONE
	} idct_state_e;

	typedef enum logic [1:0] {MAC_NONE, MAC_FIRST, MAC_ACC, MAC_LAST} mac_op_e;

	typedef enum logic {PASS_ROW, PASS_COL} pass_e;

endpackage

//--- hw/idct_block_ram.sv
`timescale 1ns/1ps

module idct_block_ram import idct_pkg::*; #(
	parameter int WIDTH = 8
) (
	input  logic             CLOCK_50_I,
	input  logic             wr_en,
	input  logic [IDX_W-1:0] wr_addr,
	input  logic [WIDTH-1:0] wr_data,
	input  logic [IDX_W-1:0] rd_addr,
	output logic [WIDTH-1:0] rd_data
);

	logic [WIDTH-1:0] mem [BLOCK_SIZE];

	// one write port, one registered read port
	always_ff @(posedge CLOCK_50_I) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

//--- hw/idct_cos_rom.sv
`timescale 1ns/1ps

module idct_cos_rom import idct_pkg::*; (
	input  logic [IDX_W-1:0]        cos_idx,
	output logic signed [COS_W-1:0] cos_val
);

	// entry 8x+u is 2048*a(u)*cos((2x+1)u*pi/16), truncated toward zero
	logic [TERM_W-1:0] x;
	logic [TERM_W-1:0] u;
	logic [IDX_W:0]    angle;
	logic [4:0]        k;
	logic [TERM_W:0]   m;
	logic              neg;
	logic [COS_W-1:0]  mag;

	assign x = cos_idx[IDX_W-1:TERM_W];
	assign u = cos_idx[TERM_W-1:0];

	// angle in units of pi/16
	assign angle = {x, 1'b1} * u;

	always_comb begin
		k = angle[4:0];
		// mirror the second half period onto 0..16
		if (k > 5'd16) begin
			k = 5'd0 - k;
		end
		neg = (k > 5'd8);
		m = neg ? 4'(5'd16 - k) : k[3:0];
		case (m)
			4'd0: mag = 13'd2048;
			4'd1: mag = 13'd2008;
			4'd2: mag = 13'd1892;
			4'd3: mag = 13'd1702;
			4'd4: mag = 13'd1448;
			4'd5: mag = 13'd1137;
			4'd6: mag = 13'd783;
			4'd7: mag = 13'd399;
			default: mag = '0;
		endcase
		if (u == '0) begin
			cos_val = COS_W'(COS_DC);
		end else if (neg) begin
			cos_val = -$signed(mag);
		end else begin
			cos_val = $signed(mag);
		end
	end

endmodule

//--- hw/idct_mac.sv
`timescale 1ns/1ps

module idct_mac import idct_pkg::*; (
	input  logic                     CLOCK_50_I,
	input  logic                     resetn,
	input  logic signed [COEF_W-1:0] coef_rd_data,
	input  logic signed [ACC_W-1:0]  t_rd_data,
	input  logic signed [COS_W-1:0]  cos_val,
	input  mac_op_e                  mac_op,
	input  pass_e                    pass,
	input  logic [IDX_W-1:0]         dst_idx,
	output logic                     t_wr_en,
	output logic [IDX_W-1:0]         t_wr_addr,
	output logic [ACC_W-1:0]         t_wr_data,
	output logic                     pixel_wr_en,
	output logic [IDX_W-1:0]         pixel_wr_addr,
	output logic [PIXEL_W-1:0]       pixel_wr_data
);

	mac_op_e                 op_q;
	logic [IDX_W-1:0]        dst_q;
	logic [IDX_W-1:0]        wr_addr;
	logic signed [ACC_W-1:0] operand;
	logic signed [ACC_W-1:0] product;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_next;
	logic signed [ACC_W-1:0] scaled;

	// coefficient in the row pass, scaled T in the column pass
	assign operand = (pass == PASS_ROW) ? ACC_W'(coef_rd_data) : (t_rd_data >>> ROW_SHIFT);
	assign product = operand * cos_val;
	assign acc_next = (op_q == MAC_FIRST) ? product : acc + product;

	// op and destination wait one cycle for the ram read
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			op_q <= MAC_NONE;
			t_wr_en <= 1'b0;
			pixel_wr_en <= 1'b0;
		end else begin
			op_q <= mac_op;
			t_wr_en <= (op_q == MAC_LAST) && (pass == PASS_ROW);
			pixel_wr_en <= (op_q == MAC_LAST) && (pass == PASS_COL);
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		dst_q <= dst_idx;
		if (op_q != MAC_NONE) begin
			acc <= acc_next;
		end
		if (op_q == MAC_LAST) begin
			wr_addr <= dst_q;
		end
	end

	assign t_wr_addr = wr_addr;
	assign pixel_wr_addr = wr_addr;
	assign t_wr_data = acc;

	// final scale and clip to a pixel
	assign scaled = acc >>> COL_SHIFT;

	always_comb begin
		if (scaled < 0) begin
			pixel_wr_data = '0;
		end else if (scaled > PIXEL_MAX) begin
			pixel_wr_data = PIXEL_W'(PIXEL_MAX);
		end else begin
			pixel_wr_data = scaled[PIXEL_W-1:0];
		end
	end

endmodule

//--- hw/idct_ctrl.sv
`timescale 1ns/1ps

module idct_ctrl import idct_pkg::*; (
	input  logic             CLOCK_50_I,
	input  logic             resetn,
	input  logic             start,
	output logic             busy_clear,
	output logic             done_set,
	output logic [IDX_W-1:0] coef_rd_addr,
	output logic [IDX_W-1:0] t_rd_addr,
	output logic [IDX_W-1:0] cos_idx,
	output mac_op_e          mac_op,
	output pass_e            pass,
	output logic [IDX_W-1:0] dst_idx
);

	idct_state_e       state;
	logic [CNT_W-1:0]  cnt;
	logic              issuing;
	logic [TERM_W-1:0] term;
	logic [TERM_W-1:0] col;
	logic [TERM_W-1:0] row;

	// cnt = {output row, output column, term of the sum}
	assign term = cnt[TERM_W-1:0];
	assign col = cnt[2*TERM_W-1:TERM_W];
	assign row = cnt[CNT_W-1:2*TERM_W];
	assign issuing = (state == ROW_PASS) || (state == COL_PASS);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					if (start) begin
						state <= ROW_PASS;
					end
				end
				ROW_PASS: begin
					cnt <= cnt + 1'b1;
					if (&cnt) begin
						state <= ROW_DRAIN;
					end
				end
				ROW_DRAIN: begin
					if (cnt == CNT_W'(DRAIN_LEN - 1)) begin
						cnt <= '0;
						state <= COL_PASS;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				COL_PASS: begin
					cnt <= cnt + 1'b1;
					if (&cnt) begin
						state <= COL_DRAIN;
					end
				end
				COL_DRAIN: begin
					if (cnt == CNT_W'(DRAIN_LEN - 1)) begin
						cnt <= '0;
						state <= DONE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign pass = ((state == COL_PASS) || (state == COL_DRAIN)) ? PASS_COL : PASS_ROW;

	// row pass reads S[r][u], column pass reads T[v][x]
	assign coef_rd_addr = {row, term};
	assign t_rd_addr = {term, col};
	assign dst_idx = {row, col};

	// cosine index lags by one so it meets the ram data
	always_ff @(posedge CLOCK_50_I) begin
		cos_idx <= (pass == PASS_COL) ? {row, term} : {col, term};
	end

	always_comb begin
		if (!issuing) begin
			mac_op = MAC_NONE;
		end else if (term == '0) begin
			mac_op = MAC_FIRST;
		end else if (&term) begin
			mac_op = MAC_LAST;
		end else begin
			mac_op = MAC_ACC;
		end
	end

	// last pixel write lands before done is raised
	assign done_set = (state == DONE);
	assign busy_clear = (state == DONE);

endmodule

//--- hw/idct_apb_regs.sv
`timescale 1ns/1ps

module idct_apb_regs import idct_pkg::*; (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	input  logic [PIXEL_W-1:0]    pixel_rd_data,
	input  logic                  busy_clear,
	input  logic                  done_set,
	output logic [APB_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  coef_wr_en,
	output logic [IDX_W-1:0]      coef_wr_addr,
	output logic [COEF_W-1:0]     coef_wr_data,
	output logic [IDX_W-1:0]      pixel_rd_addr,
	output logic                  start,
	output logic                  done
);

	logic busy;
	logic access;
	logic sel_coef;
	logic sel_ctrl;
	logic sel_status;
	logic sel_pixel;
	logic slv_err;

	assign access = psel && penable;
	assign pready = 1'b1;

	// 64-word windows for coefficients and pixels
	assign sel_coef = (paddr[APB_ADDR_W-1:WIN_LSB] == COEF_BASE[APB_ADDR_W-1:WIN_LSB]);
	assign sel_pixel = (paddr[APB_ADDR_W-1:WIN_LSB] == PIXEL_BASE[APB_ADDR_W-1:WIN_LSB]);
	assign sel_ctrl = (paddr == CTRL_ADDR);
	assign sel_status = (paddr == STATUS_ADDR);

	always_comb begin
		if (sel_coef) begin
			slv_err = pwrite && busy;
		end else if (sel_ctrl) begin
			slv_err = pwrite && pwdata[0] && busy;
		end else if (sel_status) begin
			slv_err = 1'b0;
		end else if (sel_pixel) begin
			slv_err = !pwrite && busy;
		end else begin
			slv_err = 1'b1;
		end
	end

	assign pslverr = access && slv_err;

	assign start = access && pwrite && sel_ctrl && pwdata[0] && !busy;
	assign coef_wr_en = access && pwrite && sel_coef && !busy;
	assign coef_wr_addr = paddr[WIN_LSB-1:2];
	assign coef_wr_data = pwdata[COEF_W-1:0];

	// pixel ram samples the address in the setup phase
	assign pixel_rd_addr = paddr[WIN_LSB-1:2];

	always_comb begin
		prdata = '0;
		if (sel_status) begin
			prdata[1:0] = {done, busy};
		end else if (sel_pixel && !busy) begin
			prdata = APB_DATA_W'(pixel_rd_data);
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else begin
				if (busy_clear) begin
					busy <= 1'b0;
				end
				if (done_set) begin
					done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/idct_top.sv
`timescale 1ns/1ps

module idct_top import idct_pkg::*; (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  done
);

	logic                coef_wr_en;
	logic [IDX_W-1:0]    coef_wr_addr;
	logic [COEF_W-1:0]   coef_wr_data;
	logic [IDX_W-1:0]    coef_rd_addr;
	logic [COEF_W-1:0]   coef_rd_data;
	logic                t_wr_en;
	logic [IDX_W-1:0]    t_wr_addr;
	logic [ACC_W-1:0]    t_wr_data;
	logic [IDX_W-1:0]    t_rd_addr;
	logic [ACC_W-1:0]    t_rd_data;
	logic                pixel_wr_en;
	logic [IDX_W-1:0]    pixel_wr_addr;
	logic [PIXEL_W-1:0]  pixel_wr_data;
	logic [IDX_W-1:0]    pixel_rd_addr;
	logic [PIXEL_W-1:0]  pixel_rd_data;
	logic                start;
	logic                busy_clear;
	logic                done_set;
	logic [IDX_W-1:0]    cos_idx;
	logic [COS_W-1:0]    cos_val;
	mac_op_e             mac_op;
	pass_e               pass;
	logic [IDX_W-1:0]    dst_idx;

	idct_apb_regs u_regs (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pixel_rd_data(pixel_rd_data), .busy_clear(busy_clear), .done_set(done_set),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.coef_wr_en(coef_wr_en), .coef_wr_addr(coef_wr_addr), .coef_wr_data(coef_wr_data),
		.pixel_rd_addr(pixel_rd_addr), .start(start), .done(done)
	);

	// coefficients in, intermediate T, pixels out
	idct_block_ram #(.WIDTH(COEF_W)) coef_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(coef_wr_en), .wr_addr(coef_wr_addr),
		.wr_data(coef_wr_data), .rd_addr(coef_rd_addr), .rd_data(coef_rd_data)
	);

	idct_block_ram #(.WIDTH(ACC_W)) t_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(t_wr_en), .wr_addr(t_wr_addr),
		.wr_data(t_wr_data), .rd_addr(t_rd_addr), .rd_data(t_rd_data)
	);

	idct_block_ram #(.WIDTH(PIXEL_W)) pixel_ram (
		.CLOCK_50_I(CLOCK_50_I), .wr_en(pixel_wr_en), .wr_addr(pixel_wr_addr),
		.wr_data(pixel_wr_data), .rd_addr(pixel_rd_addr), .rd_data(pixel_rd_data)
	);

	idct_ctrl u_ctrl (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .start(start),
		.busy_clear(busy_clear), .done_set(done_set),
		.coef_rd_addr(coef_rd_addr), .t_rd_addr(t_rd_addr), .cos_idx(cos_idx),
		.mac_op(mac_op), .pass(pass), .dst_idx(dst_idx)
	);

	idct_cos_rom u_cos_rom (
		.cos_idx(cos_idx), .cos_val(cos_val)
	);

	idct_mac u_mac (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
		.coef_rd_data(coef_rd_data), .t_rd_data(t_rd_data), .cos_val(cos_val),
		.mac_op(mac_op), .pass(pass), .dst_idx(dst_idx),
		.t_wr_en(t_wr_en), .t_wr_addr(t_wr_addr), .t_wr_data(t_wr_data),
		.pixel_wr_en(pixel_wr_en), .pixel_wr_addr(pixel_wr_addr),
		.pixel_wr_data(pixel_wr_data)
	);

endmodule

//--- dv/idct_properties.sv
`timescale 1ns/1ps

module idct_properties (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic busy,
	input logic done,
	input logic start
);

	// zero wait state slave
	pready_high: assert property (@(posedge CLOCK_50_I) disable iff (!resetn) pready)
		else $error("pready dropped low");

	pslverr_in_access: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		pslverr |-> (psel && penable))
		else $error("pslverr raised outside an access phase");

	busy_done_exclusive: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		!(busy && done))
		else $error("busy and done high together");

	// only a new start may clear done
	done_sticky: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(done && !start) |=> done)
		else $error("done cleared without a start");

endmodule

bind idct_apb_regs idct_properties u_props (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.busy(busy),
	.done(done),
	.start(start)
);

//--- dv/idct_tb.sv
`timescale 1ns/1ps

module idct_tb import idct_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 1100;
	localparam int POLL_LIMIT  = 1000;
	localparam real PI         = 3.14159265358979;

	logic                  CLOCK_50_I;
	logic                  resetn;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  done;

	integer                seed;
	int                    test_errors;
	int                    error_count;
	int                    tests_run;
	int                    tests_failed;
	int                    dc_level;
	int                    coef [BLOCK_SIZE];
	int                    expect_px [BLOCK_SIZE];
	int                    got_px [BLOCK_SIZE];
	logic [APB_DATA_W-1:0] rd_data;
	logic                  apb_err;

	idct_top dut (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .done(done)
	);

	always #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;

	// watchdog at three times the expected length of all tests
	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD * 3);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_value(input string name, input longint expected, input longint actual);
		assert (expected == actual) else begin
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
			input logic [APB_DATA_W-1:0] data, output logic err);
		@(negedge CLOCK_50_I);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge CLOCK_50_I);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		err = pslverr;
		@(negedge CLOCK_50_I);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
			output logic [APB_DATA_W-1:0] data, output logic err);
		@(negedge CLOCK_50_I);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge CLOCK_50_I);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		data = prdata;
		err = pslverr;
		@(negedge CLOCK_50_I);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// 2048*a(u)*cos((2x+1)u*pi/16) truncated toward zero like the table
	function automatic int cos_entry(input int idx);
		int  x;
		int  u;
		real a;
		x = idx / BLOCK_DIM;
		u = idx % BLOCK_DIM;
		a = (u == 0) ? 1.0 / $sqrt(2.0) : 1.0;
		return $rtoi(2048.0 * a * $cos((2 * x + 1) * u * PI / 16.0));
	endfunction

	function automatic void compute_model();
		int t [BLOCK_SIZE];
		int sum;
		for (int r = 0; r < BLOCK_DIM; r++) begin
			for (int x = 0; x < BLOCK_DIM; x++) begin
				sum = 0;
				for (int u = 0; u < BLOCK_DIM; u++) begin
					sum += coef[r * BLOCK_DIM + u] * cos_entry(x * BLOCK_DIM + u);
				end
				t[r * BLOCK_DIM + x] = sum;
			end
		end
		// columns use T scaled down, then shift and clip
		for (int y = 0; y < BLOCK_DIM; y++) begin
			for (int x = 0; x < BLOCK_DIM; x++) begin
				sum = 0;
				for (int v = 0; v < BLOCK_DIM; v++) begin
					sum += (t[v * BLOCK_DIM + x] >>> ROW_SHIFT) * cos_entry(y * BLOCK_DIM + v);
				end
				sum = sum >>> COL_SHIFT;
				if (sum < 0) begin
					sum = 0;
				end else if (sum > PIXEL_MAX) begin
					sum = PIXEL_MAX;
				end
				expect_px[y * BLOCK_DIM + x] = sum;
			end
		end
	endfunction

	task automatic load_block(input string name);
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			apb_write(COEF_BASE + APB_ADDR_W'(i * 4), APB_DATA_W'(coef[i]), apb_err);
			check_value({name, " coef write err"}, 0, apb_err);
		end
	endtask

	task automatic wait_done(input string name);
		logic [APB_DATA_W-1:0] status;
		int                    polls;
		status = '0;
		polls = 0;
		while (!status[1] && polls < POLL_LIMIT) begin
			apb_read(STATUS_ADDR, status, apb_err);
			polls++;
			// busy must be gone by the time done shows
			if (status[1]) begin
				check_value({name, " busy at done"}, 0, status[0]);
			end
		end
		assert (status[1]) else begin
			$display("%s: done did not rise within %0d status polls", name, POLL_LIMIT);
			test_errors++;
		end
		check_value({name, " done port"}, 1, done);
	endtask

	task automatic read_pixels(input string name);
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			apb_read(PIXEL_BASE + APB_ADDR_W'(i * 4), rd_data, apb_err);
			check_value($sformatf("%s pixel %0d err", name, i), 0, apb_err);
			check_value($sformatf("%s pixel %0d", name, i), expect_px[i], rd_data);
			got_px[i] = int'(rd_data);
		end
	endtask

	task automatic run_and_check(input string name);
		load_block(name);
		compute_model();
		apb_write(CTRL_ADDR, 32'h1, apb_err);
		check_value({name, " start err"}, 0, apb_err);
		wait_done(name);
		read_pixels(name);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
			tests_failed++;
		end
		error_count += test_errors;
		test_errors = 0;
	endtask

	function automatic void clear_coefs();
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			coef[i] = 0;
		end
	endfunction

	initial begin
		CLOCK_50_I = 1'b0;
		resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'hcab4_bbb2;
		test_errors = 0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		dc_level = 0;
		repeat (2) @(posedge CLOCK_50_I);
		@(negedge CLOCK_50_I);
		resetn = 1'b1;

		apb_read(STATUS_ADDR, rd_data, apb_err);
		check_value("reset_state status", 0, rd_data);
		check_value("reset_state status err", 0, apb_err);
		check_value("reset_state done", 0, done);
		apb_read(12'h300, rd_data, apb_err);
		check_value("reset_state unmapped err", 1, apb_err);
		check_value("reset_state unmapped data", 0, rd_data);
		finish_test("reset_state");

		// single dc term gives a flat block
		clear_coefs();
		coef[0] = 800;
		run_and_check("dc_block");
		// only row 0 of T is non-zero and every T in it is C times the dc constant
		dc_level = (((800 * cos_entry(0)) >>> ROW_SHIFT) * cos_entry(0)) >>> COL_SHIFT;
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			check_value($sformatf("dc_block flat %0d", i), dc_level, got_px[i]);
		end
		finish_test("dc_block");

		for (int i = 0; i < BLOCK_SIZE; i++) begin
			coef[i] = $random(seed) % 513;
		end
		run_and_check("random_block");
		finish_test("random_block");

		clear_coefs();
		coef[0] = 20000;
		run_and_check("clip_high");
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			check_value($sformatf("clip_high level %0d", i), PIXEL_MAX, got_px[i]);
		end
		finish_test("clip_high");

		coef[0] = -20000;
		run_and_check("clip_low");
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			check_value($sformatf("clip_low level %0d", i), 0, got_px[i]);
		end
		finish_test("clip_low");

		// every access below lands while the engine is busy
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			coef[i] = $random(seed) % 513;
		end
		load_block("busy_protocol");
		compute_model();
		apb_write(CTRL_ADDR, 32'h1, apb_err);
		check_value("busy_protocol start err", 0, apb_err);
		apb_write(COEF_BASE, 32'h7fff, apb_err);
		check_value("busy_protocol coef write err", 1, apb_err);
		apb_write(CTRL_ADDR, 32'h1, apb_err);
		check_value("busy_protocol restart err", 1, apb_err);
		apb_read(PIXEL_BASE, rd_data, apb_err);
		check_value("busy_protocol pixel read err", 1, apb_err);
		apb_read(STATUS_ADDR, rd_data, apb_err);
		check_value("busy_protocol status", 1, rd_data);
		check_value("busy_protocol done port", 0, done);
		wait_done("busy_protocol");
		read_pixels("busy_protocol");
		finish_test("busy_protocol");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- idct_top.f
hw/idct_pkg.sv
hw/idct_block_ram.sv
hw/idct_cos_rom.sv
hw/idct_mac.sv
hw/idct_ctrl.sv
hw/idct_apb_regs.sv
hw/idct_top.sv
dv/idct_properties.sv
dv/idct_tb.sv

//--- run.sh
#!/bin/sh
# build and run the idct testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module idct_tb -f idct_top.f -o idct_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/idct_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
